/* source/delay_cfg_pkg.sv */
`default_nettype none

package delay_cfg_pkg;

    // signed audio word
    localparam int SAMPLE_W = 24;

    // selectable delay codes for the near tap
    localparam int DELTA_START = 147;
    localparam int DELTA_LAST = 169;

    // far tap sits this many samples behind the near tap
    localparam int TAP_GAP = 30;

    // deep enough for the far tap at the largest delay code
    localparam int BUFFER_LENGTH = TAP_GAP + DELTA_LAST - DELTA_START + 1;

    // ring pointer width, also used for the fill counter
    localparam int PTR_W = $clog2(BUFFER_LENGTH);

endpackage

`default_nettype wire

/* source/delay_types_pkg.sv */
`default_nettype none

package delay_types_pkg;

    // one sample leaving the capture stage
    typedef struct packed {
        logic valid;
        // enough history is stored for both taps
        logic primed;
        logic signed [delay_cfg_pkg::SAMPLE_W-1:0] data;
    } cap_beat_t;

    // both delayed taps of one sample
    typedef struct packed {
        logic valid;
        logic signed [delay_cfg_pkg::SAMPLE_W-1:0] near;
        logic signed [delay_cfg_pkg::SAMPLE_W-1:0] far;
    } tap_pair_t;

endpackage

`default_nettype wire

/* source/sample_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_capture (
    input  logic                                   i_LRCK,
    input  logic                                   i_rst,
    input  logic                                   i_start,
    input  logic                                   i_sample_valid,
    input  logic signed [delay_cfg_pkg::SAMPLE_W-1:0] i_sample,
    output delay_types_pkg::cap_beat_t             o_beat
);

    logic                             running_r;
    logic [delay_cfg_pkg::PTR_W-1:0]  count_r;
    logic                             accept;
    logic                             full;
    delay_types_pkg::cap_beat_t       beat_r;

    // start takes effect one cycle later, a strobe in the same cycle is dropped
    assign accept = running_r && i_sample_valid;

    // history covers the far tap from this sample on
    assign full = (count_r ==
                   delay_cfg_pkg::PTR_W'(delay_cfg_pkg::BUFFER_LENGTH - 1));

    // idle until the first start, then stays running until reset
    always_ff @(posedge i_LRCK or posedge i_rst) begin
        if (i_rst) begin
            running_r <= 1'b0;
        end else if (i_start) begin
            running_r <= 1'b1;
        end
    end

    // fill counter saturates once the ring is primed
    always_ff @(posedge i_LRCK or posedge i_rst) begin
        if (i_rst) begin
            count_r <= '0;
        end else if (accept && !full) begin
            count_r <= count_r + 1'b1;
        end
    end

    always_ff @(posedge i_LRCK or posedge i_rst) begin
        if (i_rst) begin
            beat_r <= '0;
        end else begin
            beat_r.valid <= accept;
            if (accept) begin
                beat_r.data   <= i_sample;
                beat_r.primed <= full;
            end
        end
    end

    assign o_beat = beat_r;

endmodule

`default_nettype wire

/* source/sample_ring.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_ring (
    input  logic                       i_LRCK,
    input  logic                       i_rst,
    input  logic [7:0]                 i_delta,
    input  delay_types_pkg::cap_beat_t i_beat,
    output delay_types_pkg::tap_pair_t o_taps
);

    logic signed [delay_cfg_pkg::SAMPLE_W-1:0] mem_r [delay_cfg_pkg::BUFFER_LENGTH];
    logic [delay_cfg_pkg::PTR_W-1:0]           wr_ptr_r;
    logic [delay_cfg_pkg::PTR_W-1:0]           wr_ptr_next;
    logic [delay_cfg_pkg::PTR_W-1:0]           near_off;
    logic [delay_cfg_pkg::PTR_W-1:0]           far_off;
    logic [delay_cfg_pkg::PTR_W-1:0]           near_addr;
    logic [delay_cfg_pkg::PTR_W-1:0]           far_addr;
    logic signed [delay_cfg_pkg::SAMPLE_W-1:0] near_val;
    delay_types_pkg::tap_pair_t                taps_r;

    // address that lies off samples behind ptr, modulo the ring depth
    function automatic logic [delay_cfg_pkg::PTR_W-1:0] ring_back(
        input logic [delay_cfg_pkg::PTR_W-1:0] ptr,
        input logic [delay_cfg_pkg::PTR_W-1:0] off
    );
        logic [delay_cfg_pkg::PTR_W:0] wrapped;
        wrapped = {1'b0, ptr} + (delay_cfg_pkg::PTR_W + 1)'(delay_cfg_pkg::BUFFER_LENGTH)
                  - {1'b0, off};
        if (wrapped >= (delay_cfg_pkg::PTR_W + 1)'(delay_cfg_pkg::BUFFER_LENGTH)) begin
            wrapped = wrapped - (delay_cfg_pkg::PTR_W + 1)'(delay_cfg_pkg::BUFFER_LENGTH);
        end
        return wrapped[delay_cfg_pkg::PTR_W-1:0];
    endfunction

    // clamp the delay code, then make it zero based
    always_comb begin
        if (i_delta < 8'(delay_cfg_pkg::DELTA_START)) begin
            near_off = '0;
        end else if (i_delta > 8'(delay_cfg_pkg::DELTA_LAST)) begin
            near_off = delay_cfg_pkg::PTR_W'(delay_cfg_pkg::DELTA_LAST
                                             - delay_cfg_pkg::DELTA_START);
        end else begin
            near_off = delay_cfg_pkg::PTR_W'(i_delta - 8'(delay_cfg_pkg::DELTA_START));
        end
    end

    assign far_off   = near_off + delay_cfg_pkg::PTR_W'(delay_cfg_pkg::TAP_GAP);
    assign near_addr = ring_back(wr_ptr_r, near_off);
    assign far_addr  = ring_back(wr_ptr_r, far_off);

    // zero delay means the sample being written this cycle
    assign near_val = (near_off == '0) ? i_beat.data : mem_r[near_addr];

    assign wr_ptr_next =
        (wr_ptr_r == delay_cfg_pkg::PTR_W'(delay_cfg_pkg::BUFFER_LENGTH - 1)) ?
        '0 : wr_ptr_r + 1'b1;

    always_ff @(posedge i_LRCK or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr_r <= '0;
            for (int i = 0; i < delay_cfg_pkg::BUFFER_LENGTH; i++) begin
                mem_r[i] <= '0;
            end
        end else if (i_beat.valid) begin
            mem_r[wr_ptr_r] <= i_beat.data;
            wr_ptr_r        <= wr_ptr_next;
        end
    end

    // taps only leave once both refer to real samples
    always_ff @(posedge i_LRCK or posedge i_rst) begin
        if (i_rst) begin
            taps_r <= '0;
        end else begin
            taps_r.valid <= i_beat.valid && i_beat.primed;
            if (i_beat.valid) begin
                taps_r.near <= near_val;
                taps_r.far  <= mem_r[far_addr];
            end
        end
    end

    assign o_taps = taps_r;

endmodule

`default_nettype wire

/* source/tap_combiner.sv */
`timescale 1ns/10ps
`default_nettype none

module tap_combiner (
    input  logic                                     i_LRCK,
    input  logic                                     i_rst,
    input  delay_types_pkg::tap_pair_t               i_taps,
    output logic                                     o_valid,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_near,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_far,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_sum,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_diff
);

    logic signed [delay_cfg_pkg::SAMPLE_W:0]   near_ext;
    logic signed [delay_cfg_pkg::SAMPLE_W:0]   far_ext;
    logic signed [delay_cfg_pkg::SAMPLE_W:0]   sum_wide;
    logic signed [delay_cfg_pkg::SAMPLE_W:0]   diff_wide;
    logic signed [delay_cfg_pkg::SAMPLE_W-1:0] sum_sat;
    logic signed [delay_cfg_pkg::SAMPLE_W-1:0] diff_sat;

    // clip a one-bit-wide result back to the sample range
    function automatic logic signed [delay_cfg_pkg::SAMPLE_W-1:0] saturate(
        input logic signed [delay_cfg_pkg::SAMPLE_W:0] x
    );
        logic signed [delay_cfg_pkg::SAMPLE_W-1:0] y;
        if (x[delay_cfg_pkg::SAMPLE_W] == x[delay_cfg_pkg::SAMPLE_W-1]) begin
            y = x[delay_cfg_pkg::SAMPLE_W-1:0];
        end else if (x[delay_cfg_pkg::SAMPLE_W]) begin
            // negative overflow
            y = {1'b1, {(delay_cfg_pkg::SAMPLE_W - 1){1'b0}}};
        end else begin
            y = {1'b0, {(delay_cfg_pkg::SAMPLE_W - 1){1'b1}}};
        end
        return y;
    endfunction

    assign near_ext = {i_taps.near[delay_cfg_pkg::SAMPLE_W-1], i_taps.near};
    assign far_ext  = {i_taps.far[delay_cfg_pkg::SAMPLE_W-1], i_taps.far};

    assign sum_wide  = near_ext + far_ext;
    assign diff_wide = near_ext - far_ext;

    assign sum_sat  = saturate(sum_wide);
    assign diff_sat = saturate(diff_wide);

    // outputs hold between strobes
    always_ff @(posedge i_LRCK or posedge i_rst) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_near  <= '0;
            o_far   <= '0;
            o_sum   <= '0;
            o_diff  <= '0;
        end else begin
            o_valid <= i_taps.valid;
            if (i_taps.valid) begin
                o_near <= i_taps.near;
                o_far  <= i_taps.far;
                o_sum  <= sum_sat;
                o_diff <= diff_sat;
            end
        end
    end

endmodule

`default_nettype wire

/* source/delay_line_top.sv */
`timescale 1ns/10ps
`default_nettype none

module delay_line_top (
    input  logic                                     i_LRCK,
    input  logic                                     i_rst,
    input  logic                                     i_start,
    input  logic                                     i_sample_valid,
    input  logic signed [delay_cfg_pkg::SAMPLE_W-1:0] i_sample,
    input  logic [7:0]                               i_delta,
    output logic                                     o_valid,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_near,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_far,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_sum,
    output logic signed [delay_cfg_pkg::SAMPLE_W-1:0] o_diff
);

    delay_types_pkg::cap_beat_t beat;
    delay_types_pkg::tap_pair_t taps;

    // one register stage each, three cycles strobe to o_valid
    sample_capture u_capture (
        .i_LRCK         (i_LRCK),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .o_beat         (beat)
    );

    sample_ring u_ring (
        .i_LRCK  (i_LRCK),
        .i_rst   (i_rst),
        .i_delta (i_delta),
        .i_beat  (beat),
        .o_taps  (taps)
    );

    tap_combiner u_combiner (
        .i_LRCK  (i_LRCK),
        .i_rst   (i_rst),
        .i_taps  (taps),
        .o_valid (o_valid),
        .o_near  (o_near),
        .o_far   (o_far),
        .o_sum   (o_sum),
        .o_diff  (o_diff)
    );

endmodule

`default_nettype wire

/* tb/delay_line_model.svh */
`ifndef DELAY_LINE_MODEL_SVH
`define DELAY_LINE_MODEL_SVH

typedef logic signed [delay_cfg_pkg::SAMPLE_W-1:0] sample_t;

// one expected output pulse, due is the cycle o_valid should be seen
typedef struct packed {
    logic [31:0] due;
    sample_t     near;
    sample_t     far;
    sample_t     sum;
    sample_t     diff;
} expect_t;

// accepted samples since start, indexed by sample number
sample_t hist_q [$];

// delay code to zero based near delay
function automatic int clamp_delay(input int code);
    int d;
    if (code < delay_cfg_pkg::DELTA_START) begin
        d = 0;
    end else if (code > delay_cfg_pkg::DELTA_LAST) begin
        d = delay_cfg_pkg::DELTA_LAST - delay_cfg_pkg::DELTA_START;
    end else begin
        d = code - delay_cfg_pkg::DELTA_START;
    end
    return d;
endfunction

// integer add or subtract, clipped to the signed sample range
function automatic sample_t sat_combine(input sample_t a, input sample_t b, input bit subtract);
    int full;
    int hi;
    int lo;
    hi = (1 << (delay_cfg_pkg::SAMPLE_W - 1)) - 1;
    lo = -(1 << (delay_cfg_pkg::SAMPLE_W - 1));
    full = subtract ? int'(a) - int'(b) : int'(a) + int'(b);
    if (full > hi) begin
        full = hi;
    end else if (full < lo) begin
        full = lo;
    end
    return full[delay_cfg_pkg::SAMPLE_W-1:0];
endfunction

// near is sample n-d, far sits TAP_GAP further back
function automatic expect_t expected_outputs(input int n, input int code);
    expect_t e;
    int d;
    d = clamp_delay(code);
    e.due  = '0;
    e.near = hist_q[n - d];
    e.far  = hist_q[n - d - delay_cfg_pkg::TAP_GAP];
    e.sum  = sat_combine(e.near, e.far, 1'b0);
    e.diff = sat_combine(e.near, e.far, 1'b1);
    return e;
endfunction

`endif

/* tb/tb_delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_delay_line;

    `include "delay_line_model.svh"

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_GAP = 6;
    localparam int MAX_GAP = 3;
    localparam int LATENCY = 3;
    localparam int DRAIN = 10;
    localparam int PRE_LEN = 5;
    localparam int PRIME_LEN = 70;
    localparam int BURST_LEN = 40;
    localparam int N_BURSTS = 6;
    localparam int TOTAL_SAMPLES = PRE_LEN + PRIME_LEN + N_BURSTS * BURST_LEN;
    localparam int STIM_CYCLES = RESET_CYCLES + TOTAL_SAMPLES * (MAX_GAP + 1)
                                 + (2 * N_BURSTS + 6) * IDLE_GAP + LATENCY + DRAIN + 8;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

    localparam sample_t FULL_POS = {1'b0, {(delay_cfg_pkg::SAMPLE_W - 1){1'b1}}};
    localparam sample_t FULL_NEG = {1'b1, {(delay_cfg_pkg::SAMPLE_W - 1){1'b0}}};

    logic       i_LRCK;
    logic       i_rst;
    logic       i_start;
    logic       i_sample_valid;
    sample_t    i_sample;
    logic [7:0] i_delta;
    logic       o_valid;
    sample_t    o_near;
    sample_t    o_far;
    sample_t    o_sum;
    sample_t    o_diff;

    integer  seed = 32'h4f2c97b9;
    int      cyc = 0;
    int      cur_delta;
    bit      capture_on = 1'b0;
    int      expect_count = 0;
    int      pulse_count = 0;
    int      value_errors = 0;
    int      timing_errors = 0;
    int      other_errors = 0;
    string   test_name = "reset";
    expect_t exp_q [$];
    string   name_q [$];

    delay_line_top u_dut (
        .i_LRCK         (i_LRCK),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .i_delta        (i_delta),
        .o_valid        (o_valid),
        .o_near         (o_near),
        .o_far          (o_far),
        .o_sum          (o_sum),
        .o_diff         (o_diff)
    );

    initial begin
        i_LRCK = 1'b0;
        forever #5 i_LRCK = ~i_LRCK;
    end

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge i_LRCK);
            i_sample_valid <= 1'b0;
        end
    endtask

    // strobe one sample and queue its expected outputs once primed
    task automatic send_sample(input sample_t value, input int gap);
        expect_t e;
        int n;
        @(posedge i_LRCK);
        i_sample       <= value;
        i_sample_valid <= 1'b1;
        if (capture_on) begin
            n = hist_q.size();
            hist_q.push_back(value);
            if (n >= delay_cfg_pkg::BUFFER_LENGTH - 1) begin
                e = expected_outputs(n, cur_delta);
                // cyc has not yet counted this edge
                e.due = cyc + 1 + LATENCY;
                exp_q.push_back(e);
                name_q.push_back(test_name);
                expect_count++;
            end
        end
        idle(gap);
    endtask

    task automatic start_capture();
        @(posedge i_LRCK);
        i_sample_valid <= 1'b0;
        i_start        <= 1'b1;
        @(posedge i_LRCK);
        i_start    <= 1'b0;
        capture_on = 1'b1;
    endtask

    // delay code only moves with the pipeline empty
    task automatic set_delay(input int code);
        idle(IDLE_GAP);
        i_delta   <= 8'(code);
        cur_delta = code;
        idle(IDLE_GAP);
    endtask

    task automatic run_burst(input string name, input int code, input int count,
                             input bit full_scale, input bit random_gaps);
        logic [31:0] rnd;
        sample_t value;
        int gap;
        set_delay(code);
        test_name = name;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            value = rnd[delay_cfg_pkg::SAMPLE_W-1:0];
            if (full_scale) begin
                case (rnd[31:30])
                    2'd0: value = FULL_POS;
                    2'd1: value = FULL_NEG;
                    2'd2: value = FULL_POS - sample_t'(rnd[7:0]);
                    default: value = FULL_NEG + sample_t'(rnd[7:0]);
                endcase
            end
            gap = 0;
            if (random_gaps) begin
                gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            end
            send_sample(value, gap);
        end
    endtask

    task automatic compare_word(input string name, input string field,
                                input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0d actual %0d", name, field, expected, actual);
            value_errors++;
        end
    endtask

    always @(posedge i_LRCK) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // outputs are sampled mid cycle, away from the clock edge
    always @(negedge i_LRCK) begin : check_outputs
        expect_t e;
        string name;
        if (o_valid) begin
            pulse_count++;
            if (exp_q.size() == 0) begin
                $display("o_valid pulse at cycle %0d with no sample outstanding", cyc);
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                name = name_q.pop_front();
                if (cyc != int'(e.due)) begin
                    $display("[ERROR] %s latency: expected cycle %0d actual cycle %0d",
                             name, e.due, cyc);
                    timing_errors++;
                end
                compare_word(name, "o_near", e.near, o_near);
                compare_word(name, "o_far", e.far, o_far);
                compare_word(name, "o_sum", e.sum, o_sum);
                compare_word(name, "o_diff", e.diff, o_diff);
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        i_rst          = 1'b1;
        i_start        = 1'b0;
        i_sample_valid = 1'b0;
        i_sample       = '0;
        i_delta        = 8'(delay_cfg_pkg::DELTA_START);
        cur_delta      = delay_cfg_pkg::DELTA_START;
        repeat (RESET_CYCLES) @(posedge i_LRCK);
        i_rst <= 1'b0;
        idle(IDLE_GAP);

        // strobes before start must be dropped
        test_name = "start_gating";
        for (int i = 0; i < PRE_LEN; i++) begin
            rnd = $random(seed);
            send_sample(rnd[delay_cfg_pkg::SAMPLE_W-1:0], 1);
        end
        idle(IDLE_GAP);
        start_capture();
        idle(2);

        run_burst("priming", 147, PRIME_LEN, 1'b0, 1'b0);
        run_burst("delay_158", 158, BURST_LEN, 1'b0, 1'b0);
        run_burst("delay_169", 169, BURST_LEN, 1'b0, 1'b0);
        run_burst("delay_100_low_clamp", 100, BURST_LEN, 1'b0, 1'b1);
        run_burst("delay_200_high_clamp", 200, BURST_LEN, 1'b0, 1'b1);
        run_burst("saturation", 150, BURST_LEN, 1'b1, 1'b0);

        // a second start while running changes nothing
        idle(IDLE_GAP);
        start_capture();
        run_burst("irregular_strobes", 163, BURST_LEN, 1'b0, 1'b1);

        idle(IDLE_GAP);
        while (exp_q.size() != 0) begin
            @(posedge i_LRCK);
        end
        idle(DRAIN);

        if (pulse_count != expect_count) begin
            $display("o_valid pulse count wrong: saw %0d pulses for %0d primed samples",
                     pulse_count, expect_count);
            other_errors++;
        end
        $display("value errors %0d, latency errors %0d, other errors %0d, pulses %0d of %0d",
                 value_errors, timing_errors, other_errors, pulse_count, expect_count);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+tb
source/delay_cfg_pkg.sv
source/delay_types_pkg.sv
source/sample_capture.sv
source/sample_ring.sv
source/tap_combiner.sv
source/delay_line_top.sv
tb/tb_delay_line.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the delay line testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary -j 0 -Wno-fatal \
    --top-module tb_delay_line \
    --Mdir "$BUILD_DIR" \
    -o sim_delay_line \
    -f build.f

# keep the simulator output for the pass check
"$BUILD_DIR"/sim_delay_line | tee "$LOG"

if grep -qx "NO ERRORS" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
